/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // way geometry
    localparam int SETS       = 64;
    localparam int BANKS      = 4;
    localparam int LOAD_PORTS = 2;
    localparam int WORD_BYTES = 4;

    localparam int SET_BITS  = $clog2(SETS);
    localparam int BANK_BITS = $clog2(BANKS);
    localparam int TAG_BITS  = 20;
    localparam int WORD_BITS = WORD_BYTES * 8;

    // set index within the way
    typedef logic [SET_BITS-1:0] set_idx_t;

    // address tag held per set
    typedef logic [TAG_BITS-1:0] tag_t;

    // bank of the line a load wants
    typedef logic [BANK_BITS-1:0] bank_sel_t;

    // one bank word and its byte enables
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [WORD_BYTES-1:0] byte_mask_t;

endpackage

`default_nettype wire

/* rtl/dcache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store #(
    parameter int N_LOAD = dcache_pkg::LOAD_PORTS
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,

    input  wire logic                 load_valid  [N_LOAD],
    input  wire dcache_pkg::set_idx_t load_index  [N_LOAD],

    input  wire logic                 evict_en,
    input  wire dcache_pkg::set_idx_t evict_index,

    input  wire logic                 tag_we,
    input  wire dcache_pkg::set_idx_t tag_windex,
    input  wire dcache_pkg::tag_t     tag_wtag,
    input  wire logic                 tag_wvalid,

    input  wire logic                 dirty_we,
    input  wire dcache_pkg::set_idx_t dirty_windex,
    input  wire logic                 dirty_wdata,

    output logic                      stored_valid [N_LOAD],
    output dcache_pkg::tag_t          stored_tag   [N_LOAD],

    output dcache_pkg::tag_t          evict_tag,
    output logic                      evict_valid,
    output logic                      evict_dirty
);

    localparam int N_RD = N_LOAD + 1; // load ports, then the evict port

    dcache_pkg::tag_t       tags  [dcache_pkg::SETS]; // no reset on the tag array
    logic [dcache_pkg::SETS-1:0] valid;
    logic [dcache_pkg::SETS-1:0] dirty;

    logic                 rd_en    [N_RD];
    dcache_pkg::set_idx_t rd_index [N_RD];
    dcache_pkg::tag_t     rd_tag   [N_RD];
    logic                 rd_valid [N_RD];

    // gather all read ports into one set of arrays
    always_comb begin
        for (int p = 0; p < N_LOAD; p++) begin
            rd_en[p]    = load_valid[p];
            rd_index[p] = load_index[p];
        end
        rd_en[N_LOAD]    = evict_en;
        rd_index[N_LOAD] = evict_index;
    end

    // tag array, read before this cycle's write
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[tag_windex] <= tag_wtag;
        end
        for (int p = 0; p < N_RD; p++) begin
            if (rd_en[p]) begin
                rd_tag[p] <= tags[rd_index[p]];
            end
        end
    end

    // valid and dirty bits live in flops so they can be cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid       <= '0;
            dirty       <= '0;
            evict_dirty <= 1'b0;
            for (int p = 0; p < N_RD; p++) begin
                rd_valid[p] <= 1'b0;
            end
        end else begin
            if (tag_we) begin
                valid[tag_windex] <= tag_wvalid;
            end
            if (dirty_we) begin
                dirty[dirty_windex] <= dirty_wdata;
            end
            for (int p = 0; p < N_RD; p++) begin
                if (rd_en[p]) begin
                    rd_valid[p] <= valid[rd_index[p]]; // old value on same-set write
                end
            end
            if (evict_en) begin
                evict_dirty <= dirty[evict_index];
            end
        end
    end

    // split the read ports back out
    always_comb begin
        for (int p = 0; p < N_LOAD; p++) begin
            stored_tag[p]   = rd_tag[p];
            stored_valid[p] = rd_valid[p];
        end
        evict_tag   = rd_tag[N_LOAD];
        evict_valid = rd_valid[N_LOAD];
    end

endmodule

`default_nettype wire

/* rtl/dcache_data_banks.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_banks #(
    parameter int N_LOAD = dcache_pkg::LOAD_PORTS,
    parameter int N_BANK = dcache_pkg::BANKS
) (
    input  wire logic                   clk,

    input  wire logic                   load_valid  [N_LOAD],
    input  wire dcache_pkg::set_idx_t   load_index  [N_LOAD],
    input  wire dcache_pkg::bank_sel_t  load_bank   [N_LOAD],

    input  wire dcache_pkg::byte_mask_t data_we     [N_BANK],
    input  wire dcache_pkg::set_idx_t   data_windex [N_BANK],
    input  wire dcache_pkg::word_t      data_wdata  [N_BANK],

    output logic                        grant       [N_LOAD],
    output dcache_pkg::word_t           bank_rdata  [N_BANK]
);

    logic [N_BANK-1:0]    bank_wr;  // bank taken by a write this cycle
    logic [N_BANK-1:0]    claimed;  // some load port named the bank
    dcache_pkg::set_idx_t rd_index [N_BANK];

    always_comb begin
        for (int b = 0; b < N_BANK; b++) begin
            bank_wr[b] = |data_we[b];
        end
    end

    // fixed priority, port 0 first
    always_comb begin : arb
        dcache_pkg::bank_sel_t sel;
        claimed = '0;
        for (int b = 0; b < N_BANK; b++) begin
            rd_index[b] = '0;
        end
        for (int p = 0; p < N_LOAD; p++) begin
            sel      = load_bank[p];
            grant[p] = 1'b0;
            if (load_valid[p] && !claimed[sel]) begin
                claimed[sel]  = 1'b1;
                rd_index[sel] = load_index[p];
                grant[p]      = !bank_wr[sel]; // write wins the array
            end
        end
    end

    for (genvar b = 0; b < N_BANK; b++) begin : g_bank
        dcache_pkg::word_t    mem [dcache_pkg::SETS];
        dcache_pkg::set_idx_t addr;
        logic                 rd_en;

        // one shared address per bank
        assign addr  = bank_wr[b] ? data_windex[b] : rd_index[b];
        assign rd_en = claimed[b] && !bank_wr[b];

        always_ff @(posedge clk) begin
            for (int k = 0; k < dcache_pkg::WORD_BYTES; k++) begin
                if (data_we[b][k]) begin
                    mem[addr][8*k +: 8] <= data_wdata[b][8*k +: 8];
                end
            end
            if (rd_en) begin
                bank_rdata[b] <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_hit_select.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_select #(
    parameter int N_LOAD = dcache_pkg::LOAD_PORTS,
    parameter int N_BANK = dcache_pkg::BANKS
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n,

    input  wire logic                  load_valid   [N_LOAD],
    input  wire dcache_pkg::tag_t      load_tag     [N_LOAD],
    input  wire dcache_pkg::bank_sel_t load_bank    [N_LOAD],
    input  wire logic                  grant        [N_LOAD],

    input  wire dcache_pkg::tag_t      stored_tag   [N_LOAD],
    input  wire logic                  stored_valid [N_LOAD],
    input  wire dcache_pkg::word_t     bank_rdata   [N_BANK],

    output logic                       load_hit     [N_LOAD],
    output logic                       load_replay  [N_LOAD],
    output dcache_pkg::word_t          load_data    [N_LOAD]
);

    logic                  valid_q [N_LOAD];
    logic                  grant_q [N_LOAD];
    dcache_pkg::tag_t      tag_q   [N_LOAD];
    dcache_pkg::bank_sel_t bank_q  [N_LOAD];

    // control part of the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < N_LOAD; p++) begin
                valid_q[p] <= 1'b0;
                grant_q[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < N_LOAD; p++) begin
                valid_q[p] <= load_valid[p];
                grant_q[p] <= grant[p];
            end
        end
    end

    // payload, only meaningful while valid_q
    always_ff @(posedge clk) begin
        for (int p = 0; p < N_LOAD; p++) begin
            tag_q[p]  <= load_tag[p];
            bank_q[p] <= load_bank[p];
        end
    end

    always_comb begin
        for (int p = 0; p < N_LOAD; p++) begin
            load_hit[p]    = valid_q[p] && grant_q[p] && stored_valid[p]
                             && (stored_tag[p] == tag_q[p]);
            load_replay[p] = valid_q[p] && !grant_q[p]; // bank lost, caller retries
            load_data[p]   = load_hit[p] ? bank_rdata[bank_q[p]] : '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/dcache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_way #(
    parameter int N_LOAD = dcache_pkg::LOAD_PORTS,
    parameter int N_BANK = dcache_pkg::BANKS
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    // load lookup
    input  wire logic                   load_valid   [N_LOAD],
    input  wire dcache_pkg::set_idx_t   load_index   [N_LOAD],
    input  wire dcache_pkg::tag_t       load_tag     [N_LOAD],
    input  wire dcache_pkg::bank_sel_t  load_bank    [N_LOAD],
    output logic                        load_hit     [N_LOAD],
    output logic                        load_replay  [N_LOAD],
    output dcache_pkg::word_t           load_data    [N_LOAD],

    // victim read
    input  wire logic                   evict_en,
    input  wire dcache_pkg::set_idx_t   evict_index,
    output dcache_pkg::tag_t            evict_tag,
    output logic                        evict_valid,
    output logic                        evict_dirty,

    // refill and store writes
    input  wire logic                   tag_we,
    input  wire dcache_pkg::set_idx_t   tag_windex,
    input  wire dcache_pkg::tag_t       tag_wtag,
    input  wire logic                   tag_wvalid,
    input  wire logic                   dirty_we,
    input  wire dcache_pkg::set_idx_t   dirty_windex,
    input  wire logic                   dirty_wdata,
    input  wire dcache_pkg::byte_mask_t data_we      [N_BANK],
    input  wire dcache_pkg::set_idx_t   data_windex  [N_BANK],
    input  wire dcache_pkg::word_t      data_wdata   [N_BANK]
);

    dcache_pkg::tag_t  stored_tag   [N_LOAD];
    logic              stored_valid [N_LOAD];
    logic              grant        [N_LOAD];
    dcache_pkg::word_t bank_rdata   [N_BANK];

    dcache_tag_store #(
        .N_LOAD       (N_LOAD)
    ) u_tag_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_valid   (load_valid),
        .load_index   (load_index),
        .evict_en     (evict_en),
        .evict_index  (evict_index),
        .tag_we       (tag_we),
        .tag_windex   (tag_windex),
        .tag_wtag     (tag_wtag),
        .tag_wvalid   (tag_wvalid),
        .dirty_we     (dirty_we),
        .dirty_windex (dirty_windex),
        .dirty_wdata  (dirty_wdata),
        .stored_valid (stored_valid),
        .stored_tag   (stored_tag),
        .evict_tag    (evict_tag),
        .evict_valid  (evict_valid),
        .evict_dirty  (evict_dirty)
    );

    dcache_data_banks #(
        .N_LOAD      (N_LOAD),
        .N_BANK      (N_BANK)
    ) u_data_banks (
        .clk         (clk),
        .load_valid  (load_valid),
        .load_index  (load_index),
        .load_bank   (load_bank),
        .data_we     (data_we),
        .data_windex (data_windex),
        .data_wdata  (data_wdata),
        .grant       (grant),
        .bank_rdata  (bank_rdata)
    );

    dcache_hit_select #(
        .N_LOAD       (N_LOAD),
        .N_BANK       (N_BANK)
    ) u_hit_select (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_valid   (load_valid),
        .load_tag     (load_tag),
        .load_bank    (load_bank),
        .grant        (grant),
        .stored_tag   (stored_tag),
        .stored_valid (stored_valid),
        .bank_rdata   (bank_rdata),
        .load_hit     (load_hit),
        .load_replay  (load_replay),
        .load_data    (load_data)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int PERIOD      = 40; // ns
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1; // release on a rising edge
    end

endmodule

`default_nettype wire

/* verification/dcache_way_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_way_tb;

    localparam int N_LOAD        = 2;
    localparam int N_BANK        = 4;
    localparam int N_SETS        = dcache_pkg::SETS;
    localparam int RANDOM_CYCLES = 5000;

    // expected results of one request cycle
    typedef struct packed {
        logic [N_LOAD-1:0]              hit;
        logic [N_LOAD-1:0]              replay;
        dcache_pkg::word_t [N_LOAD-1:0] data;
        logic                           ev_check;
        logic                           ev_known;
        dcache_pkg::tag_t               ev_tag;
        logic                           ev_valid;
        logic                           ev_dirty;
    } expect_t;

    logic                   clk;
    logic                   arst_n;
    logic                   load_valid  [N_LOAD];
    dcache_pkg::set_idx_t   load_index  [N_LOAD];
    dcache_pkg::tag_t       load_tag    [N_LOAD];
    dcache_pkg::bank_sel_t  load_bank   [N_LOAD];
    logic                   load_hit    [N_LOAD];
    logic                   load_replay [N_LOAD];
    dcache_pkg::word_t      load_data   [N_LOAD];
    logic                   evict_en;
    dcache_pkg::set_idx_t   evict_index;
    dcache_pkg::tag_t       evict_tag;
    logic                   evict_valid;
    logic                   evict_dirty;
    logic                   tag_we;
    dcache_pkg::set_idx_t   tag_windex;
    dcache_pkg::tag_t       tag_wtag;
    logic                   tag_wvalid;
    logic                   dirty_we;
    dcache_pkg::set_idx_t   dirty_windex;
    logic                   dirty_wdata;
    dcache_pkg::byte_mask_t data_we     [N_BANK];
    dcache_pkg::set_idx_t   data_windex [N_BANK];
    dcache_pkg::word_t      data_wdata  [N_BANK];

    // reference model of the way
    dcache_pkg::tag_t  m_tag   [N_SETS];
    logic              m_known [N_SETS]; // tag written at least once
    logic              m_valid [N_SETS];
    logic              m_dirty [N_SETS];
    dcache_pkg::word_t m_word  [N_BANK][N_SETS];
    expect_t           exp_q   [$];
    logic [31:0]       lfsr;
    int                n_hit;
    int                n_replay;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dcache_way #(
        .N_LOAD (N_LOAD),
        .N_BANK (N_BANK)
    ) u_dcache_way (.*); // tb signals carry the port names

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'hD000_0001 : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic dcache_pkg::set_idx_t pick_index();
        logic [31:0] r;
        r = rand_bits(3);
        return {r[2:0], 3'b101}; // 8 sets spread over the index range
    endfunction

    function automatic dcache_pkg::tag_t pick_tag();
        logic [31:0] r;
        r = rand_bits(2);
        return {18'h1_3a5c, r[1:0]};
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_load(input int p, input logic hit, input logic replay,
                              input dcache_pkg::word_t data);
        if (load_hit[p] !== hit) begin
            report_error($sformatf("port %0d load_hit is %b, expected %b", p, load_hit[p], hit));
        end
        if (load_replay[p] !== replay) begin
            report_error($sformatf("port %0d load_replay is %b, expected %b",
                                   p, load_replay[p], replay));
        end
        if (load_data[p] !== data) begin
            report_error($sformatf("port %0d load_data is %h, expected %h",
                                   p, load_data[p], data));
        end
    endtask

    task automatic check_evict(input logic known, input dcache_pkg::tag_t tag,
                               input logic valid, input logic dirty);
        if (known && evict_tag !== tag) begin
            report_error($sformatf("evict_tag is %h, expected %h", evict_tag, tag));
        end
        if (evict_valid !== valid) begin
            report_error($sformatf("evict_valid is %b, expected %b", evict_valid, valid));
        end
        if (evict_dirty !== dirty) begin
            report_error($sformatf("evict_dirty is %b, expected %b", evict_dirty, dirty));
        end
    endtask

    task automatic drive_idle();
        for (int p = 0; p < N_LOAD; p++) begin
            load_valid[p] <= 1'b0;
            load_index[p] <= '0;
            load_tag[p]   <= '0;
            load_bank[p]  <= '0;
        end
        evict_en     <= 1'b0;
        evict_index  <= '0;
        tag_we       <= 1'b0;
        tag_windex   <= '0;
        tag_wtag     <= '0;
        tag_wvalid   <= 1'b0;
        dirty_we     <= 1'b0;
        dirty_windex <= '0;
        dirty_wdata  <= 1'b0;
        for (int b = 0; b < N_BANK; b++) begin
            data_we[b]     <= '0;
            data_windex[b] <= '0;
            data_wdata[b]  <= '0;
        end
    endtask

    task automatic drive_load(input int p, input dcache_pkg::set_idx_t idx,
                              input dcache_pkg::tag_t tag, input dcache_pkg::bank_sel_t bank);
        load_valid[p] <= 1'b1;
        load_index[p] <= idx;
        load_tag[p]   <= tag;
        load_bank[p]  <= bank;
    endtask

    task automatic drive_evict(input dcache_pkg::set_idx_t idx);
        evict_en    <= 1'b1;
        evict_index <= idx;
    endtask

    task automatic drive_tag_write(input dcache_pkg::set_idx_t idx, input dcache_pkg::tag_t tag,
                                   input logic valid);
        tag_we     <= 1'b1;
        tag_windex <= idx;
        tag_wtag   <= tag;
        tag_wvalid <= valid;
    endtask

    task automatic drive_dirty_write(input dcache_pkg::set_idx_t idx, input logic dirty);
        dirty_we     <= 1'b1;
        dirty_windex <= idx;
        dirty_wdata  <= dirty;
    endtask

    task automatic drive_data_write(input int b, input dcache_pkg::set_idx_t idx,
                                    input dcache_pkg::byte_mask_t mask,
                                    input dcache_pkg::word_t data);
        data_we[b]     <= mask;
        data_windex[b] <= idx;
        data_wdata[b]  <= data;
    endtask

    // inputs are stable here until the next rising edge samples them
    task automatic predict_and_update();
        expect_t               e;
        logic                  taken;
        dcache_pkg::bank_sel_t bank;
        dcache_pkg::set_idx_t  idx;
        e = '0;
        for (int p = 0; p < N_LOAD; p++) begin
            bank  = load_bank[p];
            idx   = load_index[p];
            taken = |data_we[bank]; // a bank write blocks all loads on it
            for (int q = 0; q < p; q++) begin
                if (load_valid[q] && load_bank[q] == bank) begin
                    taken = 1'b1;
                end
            end
            e.replay[p] = load_valid[p] && taken;
            e.hit[p]    = load_valid[p] && !taken && m_valid[idx] && m_tag[idx] == load_tag[p];
            e.data[p]   = e.hit[p] ? m_word[bank][idx] : '0;
            n_hit       += int'(e.hit[p]);
            n_replay    += int'(e.replay[p]);
        end
        e.ev_check = evict_en;
        e.ev_known = m_known[evict_index];
        e.ev_tag   = m_tag[evict_index];
        e.ev_valid = m_valid[evict_index];
        e.ev_dirty = m_dirty[evict_index];
        exp_q.push_back(e);
        // writes land after the reads above
        if (tag_we) begin
            m_tag[tag_windex]   = tag_wtag;
            m_valid[tag_windex] = tag_wvalid;
            m_known[tag_windex] = 1'b1;
        end
        if (dirty_we) begin
            m_dirty[dirty_windex] = dirty_wdata;
        end
        for (int b = 0; b < N_BANK; b++) begin
            for (int k = 0; k < dcache_pkg::WORD_BYTES; k++) begin
                if (data_we[b][k]) begin
                    m_word[b][data_windex[b]][8*k +: 8] = data_wdata[b][8*k +: 8];
                end
            end
        end
    endtask

    task automatic check_pending();
        expect_t e;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            for (int p = 0; p < N_LOAD; p++) begin
                check_load(p, e.hit[p], e.replay[p], e.data[p]);
            end
            if (e.ev_check) begin
                check_evict(e.ev_known, e.ev_tag, e.ev_valid, e.ev_dirty);
            end
        end
    endtask

    task automatic start_cycle();
        @(posedge clk);
        drive_idle();
    endtask

    task automatic finish_cycle();
        @(negedge clk);
        check_pending();
        predict_and_update();
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("reset was not released within 20 clock cycles");
                $display("** FAIL **");
                $fatal(1);
            end
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        start_cycle();
        for (int p = 0; p < N_LOAD; p++) begin
            r = rand_bits(2);
            if (r[1:0] != 2'b00) begin
                r = rand_bits(2);
                drive_load(p, pick_index(), pick_tag(), r[1:0]);
            end
        end
        r = rand_bits(1);
        if (r[0]) begin
            drive_evict(pick_index());
        end
        r = rand_bits(3);
        if (r[2:0] == 3'b000) begin
            r = rand_bits(2);
            drive_tag_write(pick_index(), pick_tag(), r[1:0] != 2'b00);
        end
        r = rand_bits(2);
        if (r[1:0] == 2'b00) begin
            r = rand_bits(1);
            drive_dirty_write(pick_index(), r[0]);
        end
        for (int b = 0; b < N_BANK; b++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'b00) begin
                r = rand_bits(4);
                drive_data_write(b, pick_index(), r[3:0], rand_bits(32));
            end
        end
        finish_cycle();
    endtask

    initial begin
        lfsr     = 32'h7a79_8554;
        n_hit    = 0;
        n_replay = 0;
        for (int s = 0; s < N_SETS; s++) begin
            m_tag[s]   = '0;
            m_known[s] = 1'b0;
            m_valid[s] = 1'b0;
            m_dirty[s] = 1'b0;
        end
        drive_idle();
        wait_reset();
        // all sets miss and read clean after reset
        for (int s = 0; s < N_SETS; s++) begin
            start_cycle();
            drive_load(0, dcache_pkg::set_idx_t'(s), pick_tag(), 2'd0);
            drive_load(1, dcache_pkg::set_idx_t'(s), pick_tag(), 2'd1);
            drive_evict(dcache_pkg::set_idx_t'(s));
            finish_cycle();
        end
        // fill every tag and word so later compares see known data
        for (int s = 0; s < N_SETS; s++) begin
            start_cycle();
            drive_tag_write(dcache_pkg::set_idx_t'(s), pick_tag(), 1'b0);
            for (int b = 0; b < N_BANK; b++) begin
                drive_data_write(b, dcache_pkg::set_idx_t'(s), 4'hf, rand_bits(32));
            end
            finish_cycle();
        end
        start_cycle();
        drive_tag_write(6'd5, 20'h4_e971, 1'b1);
        finish_cycle();
        start_cycle();
        drive_load(0, 6'd5, 20'h4_e971, 2'd0);
        drive_load(1, 6'd5, 20'h4_e970, 2'd1);
        finish_cycle();
        start_cycle();
        drive_tag_write(6'd5, 20'h4_e971, 1'b0); // invalidate
        finish_cycle();
        start_cycle();
        drive_load(0, 6'd5, 20'h4_e971, 2'd2);
        finish_cycle();
        start_cycle();
        drive_tag_write(6'd13, 20'h0_77a2, 1'b1);
        drive_data_write(2, 6'd13, 4'b0101, 32'hdead_beef);
        finish_cycle();
        start_cycle();
        drive_load(0, 6'd13, 20'h0_77a2, 2'd2);
        drive_load(1, 6'd13, 20'h0_77a3, 2'd3);
        finish_cycle();
        start_cycle();
        drive_load(0, 6'd13, 20'h0_77a2, 2'd1);
        drive_load(1, 6'd13, 20'h0_77a2, 2'd1); // same bank, port 1 replays
        finish_cycle();
        start_cycle();
        drive_data_write(3, 6'd21, 4'b1000, 32'h1234_5678);
        drive_load(0, 6'd13, 20'h0_77a2, 2'd3);
        drive_load(1, 6'd21, 20'h0_77a2, 2'd3);
        finish_cycle();
        start_cycle();
        drive_dirty_write(6'd21, 1'b1);
        drive_tag_write(6'd21, 20'h9_0c3e, 1'b1);
        finish_cycle();
        start_cycle();
        drive_evict(6'd21);
        finish_cycle();
        // same-cycle write and read of set 13 gives old contents
        start_cycle();
        drive_tag_write(6'd13, 20'h5_5aa1, 1'b1);
        drive_dirty_write(6'd13, 1'b1);
        drive_evict(6'd13);
        drive_load(0, 6'd13, 20'h0_77a2, 2'd0);
        finish_cycle();
        start_cycle();
        drive_evict(6'd13);
        drive_load(0, 6'd13, 20'h5_5aa1, 2'd0);
        finish_cycle();
        n_hit    = 0; // count the random phase on its own
        n_replay = 0;
        repeat (RANDOM_CYCLES) begin
            drive_random();
        end
        start_cycle();
        finish_cycle();
        if (n_hit > 0 && n_replay > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("random traffic produced no hits or no replays");
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_banks.sv
rtl/dcache_hit_select.sv
rtl/dcache_way.sv
verification/tb_clock_gen.sv
verification/dcache_way_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_way_tb
RTL_TOP   ?= dcache_way
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= ** PASS **

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter rtl/%,$(SOURCES))
SIM         := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(RTL_SOURCES) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
